//--- common/soc_defines.svh
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// wishbone classic bus widths
`define WB_ADDR_W 32
`define WB_DATA_W 32
`define WB_SEL_W 4

`define RAM_ADDR_BITS 10 // 1024 words, 4 KB

// address map, every target owns one 4 KB window
`define RAM_BASE 32'h0000_0000
`define GPIO_BASE 32'h1000_0000
`define UART_BASE 32'h1000_1000
`define REGION_MASK 32'hFFFF_F000 // bits above the 4 KB window pick the target

`define GPIO_W 2 // bit 0 led, bit 1 soft reset

// serial side
`define UART_DIV 8 // clocks per bit, kept short for simulation
`define UART_STATUS_OFS 4 // busy flag register, data register sits at 0

`endif

//--- common/soc_pkg.sv
`include "soc_defines.svh"

package soc_pkg;

  typedef logic [`WB_ADDR_W-1:0] addr_t; // byte address on the bus
  typedef logic [`WB_DATA_W-1:0] word_t; // one data word
  typedef logic [`WB_SEL_W-1:0] sel_t; // one bit per byte lane

  // bus owner
  typedef enum logic [1:0] {
    arb_idle,
    arb_m0,
    arb_m1
  } arb_state_t;

  // decoded target of the current address
  typedef enum logic [1:0] {
    sel_ram,
    sel_gpio,
    sel_uart,
    sel_none
  } slave_sel_t;

  typedef enum logic [1:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_stop
  } uart_state_t;

endpackage

//--- compile.f
+incdir+common
common/soc_pkg.sv
interconnect/wb_arbiter.sv
interconnect/wb_decoder.sv
source/soc_ram.sv
source/soc_gpio.sv
source/soc_reset.sv
source/uart_tx.sv
source/soc_top.sv
sim/soc_chk.sv
sim/soc_tb.sv

//--- interconnect/wb_arbiter.sv
`timescale 1ns/1ns

module wb_arbiter import soc_pkg::*; (
  input  logic       sys_clk,
  input  logic       sys_rst, // core reset
  input  logic       m0_cyc,
  input  logic       m0_stb,
  input  logic       m0_we,
  input  addr_t      m0_adr,
  input  word_t      m0_dat_w,
  input  sel_t       m0_sel,
  output word_t      m0_dat_r,
  output logic       m0_ack,
  input  logic       m1_cyc,
  input  logic       m1_stb,
  input  logic       m1_we,
  input  addr_t      m1_adr,
  input  word_t      m1_dat_w,
  input  sel_t       m1_sel,
  output word_t      m1_dat_r,
  output logic       m1_ack,
  input  logic       bus_ack,
  input  word_t      bus_dat_r,
  output logic       bus_cyc,
  output logic       bus_stb,
  output logic       bus_we,
  output addr_t      bus_adr,
  output word_t      bus_dat_w,
  output sel_t       bus_sel
);

  arb_state_t state; // who holds the bus
  logic       last_m1; // m1 was served last
  logic       m0_req;
  logic       m1_req;

  assign m0_req = m0_cyc && m0_stb;
  assign m1_req = m1_cyc && m1_stb;

  // grant is registered, so an idle bus costs one edge before the target sees stb
  always_ff @(posedge sys_clk or posedge sys_rst) begin
    if (sys_rst) begin
      state   <= arb_idle;
      last_m1 <= 1'b1; // first tie goes to m0
    end else begin
      case (state)
        arb_idle: begin
          if (m0_req && (!m1_req || last_m1)) begin // m0 alone, or its turn
            state   <= arb_m0;
            last_m1 <= 1'b0;
          end else if (m1_req) begin
            state   <= arb_m1;
            last_m1 <= 1'b1;
          end
        end
        arb_m0:  if (!m0_cyc) state <= arb_idle; // held for the whole cycle
        arb_m1:  if (!m1_cyc) state <= arb_idle;
        default: state <= arb_idle;
      endcase
    end
  end

  // request path, nothing driven while idle
  always_comb begin
    bus_cyc   = 1'b0;
    bus_stb   = 1'b0;
    bus_we    = m0_we;
    bus_adr   = m0_adr;
    bus_dat_w = m0_dat_w;
    bus_sel   = m0_sel;
    if (state == arb_m0) begin
      bus_cyc = m0_cyc;
      bus_stb = m0_stb;
    end else if (state == arb_m1) begin
      bus_cyc   = m1_cyc;
      bus_stb   = m1_stb;
      bus_we    = m1_we;
      bus_adr   = m1_adr;
      bus_dat_w = m1_dat_w;
      bus_sel   = m1_sel;
    end
  end

  // response path, only the owner sees ack and data
  assign m0_ack   = (state == arb_m0) && bus_ack;
  assign m1_ack   = (state == arb_m1) && bus_ack;
  assign m0_dat_r = (state == arb_m0) ? bus_dat_r : '0;
  assign m1_dat_r = (state == arb_m1) ? bus_dat_r : '0;

endmodule

//--- interconnect/wb_decoder.sv
`timescale 1ns/1ns
`include "soc_defines.svh"

module wb_decoder import soc_pkg::*; (
  input  logic  sys_clk,
  input  logic  sys_rst,
  input  logic  bus_cyc,
  input  logic  bus_stb,
  input  addr_t bus_adr,
  input  logic  ram_ack,
  input  word_t ram_dat_r,
  input  logic  gpio_ack,
  input  word_t gpio_dat_r,
  input  logic  uart_ack,
  input  word_t uart_dat_r,
  output logic  ram_stb,
  output logic  gpio_stb,
  output logic  uart_stb,
  output logic  bus_ack,
  output word_t bus_dat_r
);

  slave_sel_t sel; // target of the current address
  logic       bus_req;
  logic       none_ack; // ack for an address nobody owns

  assign bus_req = bus_cyc && bus_stb;

  always_comb begin
    if ((bus_adr & `REGION_MASK) == `RAM_BASE) sel = sel_ram;
    else if ((bus_adr & `REGION_MASK) == `GPIO_BASE) sel = sel_gpio;
    else if ((bus_adr & `REGION_MASK) == `UART_BASE) sel = sel_uart;
    else sel = sel_none;
  end

  assign ram_stb  = bus_req && (sel == sel_ram); // strobes carry cyc already
  assign gpio_stb = bus_req && (sel == sel_gpio);
  assign uart_stb = bus_req && (sel == sel_uart);

  // same one-cycle latency as a real target
  always_ff @(posedge sys_clk or posedge sys_rst) begin
    if (sys_rst) none_ack <= 1'b0;
    else none_ack <= bus_req && (sel == sel_none) && !none_ack;
  end

  always_comb begin
    case (sel)
      sel_ram: begin
        bus_ack   = ram_ack;
        bus_dat_r = ram_dat_r;
      end
      sel_gpio: begin
        bus_ack   = gpio_ack;
        bus_dat_r = gpio_dat_r;
      end
      sel_uart: begin
        bus_ack   = uart_ack;
        bus_dat_r = uart_dat_r;
      end
      default: begin
        bus_ack   = none_ack;
        bus_dat_r = '0; // unmapped reads as zero
      end
    endcase
  end

endmodule

//--- run.sh
#!/bin/sh
# build and run the soc testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module soc_tb -f compile.f \
  --Mdir obj_dir -o soc_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/soc_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Verification failed" sim.log; then
  echo "FAIL"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "FAIL: simulator exited with status $sim_status"
  exit 1
fi
echo "PASS"
exit 0

//--- sim/soc_chk.sv
`timescale 1ns/1ns

module soc_chk (
  input logic sys_clk,
  input logic sys_rst, // core reset of the arbiter
  input logic m0_cyc,
  input logic m1_cyc,
  input logic m0_ack,
  input logic m1_ack,
  input logic bus_cyc,
  input logic bus_stb
);

  ack_one_hot: assert property (@(posedge sys_clk) disable iff (sys_rst) !(m0_ack && m1_ack))
    else $error("both masters acked in the same cycle");

  stb_in_cyc: assert property (@(posedge sys_clk) disable iff (sys_rst) bus_stb |-> bus_cyc)
    else $error("bus strobe without bus cycle");

  // ack only goes to a master that holds a cycle open
  m0_ack_cyc: assert property (@(posedge sys_clk) disable iff (sys_rst) m0_ack |-> m0_cyc)
    else $error("m0 acked without cyc");
  m1_ack_cyc: assert property (@(posedge sys_clk) disable iff (sys_rst) m1_ack |-> m1_cyc)
    else $error("m1 acked without cyc");

endmodule

bind wb_arbiter soc_chk soc_chk_i (
  .sys_clk(sys_clk), .sys_rst(sys_rst), .m0_cyc(m0_cyc), .m1_cyc(m1_cyc),
  .m0_ack(m0_ack), .m1_ack(m1_ack), .bus_cyc(bus_cyc), .bus_stb(bus_stb)
);

//--- sim/soc_tb.sv
`timescale 1ns/1ns
`include "soc_defines.svh"

module soc_tb import soc_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 20000; // ~4x bus traffic plus two 80 cycle frames

  logic sys_clk = 1'b0;
  logic sys_rst, m0_cyc, m0_stb, m0_we, m0_ack, m1_cyc, m1_stb, m1_we, m1_ack;
  addr_t m0_adr, m1_adr;
  word_t m0_dat_w, m0_dat_r, m1_dat_w, m1_dat_r;
  sel_t m0_sel, m1_sel;
  logic uart_txd, gpio_led;

  word_t ram_model [1 << `RAM_ADDR_BITS]; // expected ram contents
  logic [`GPIO_W-1:0] gpio_model;
  word_t got_q[$], exp_q[$];
  string what_q[$];
  logic [7:0] rx_q[$], uart_exp_q[$]; // decoded and written uart bytes
  addr_t ram_adr_q[$]; // words touched by the ram test
  int cycle_cnt = 0, m0_acks = 0, m1_acks = 0, ack_cycle = 0, rx_cnt = 0;

  soc_top soc_top_i (.*);

  always #10 sys_clk = ~sys_clk; // 20 ns period

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "simulation stopped");
  endtask

  always @(posedge sys_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
      stop_with_failure("Timeout: the tests did not finish in time");
  end

  always @(negedge sys_clk) begin
    if (m0_ack) m0_acks <= m0_acks + 1;
    if (m1_ack) m1_acks <= m1_acks + 1;
  end

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("Mismatch at %0t ns: %s got %h expected %h",
                                  $time, what, got, exp));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("Mismatch at %0t ns: %s got %b expected %b",
                                  $time, what, got, exp));
    end
  endtask

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("Mismatch at %0t ns: %s got %h expected %h",
                                  $time, what, got, exp));
    end
  endtask

  // expected read data from the address map
  function automatic word_t ref_read(input addr_t a);
    if ((a & `REGION_MASK) == `RAM_BASE) return ram_model[a[`RAM_ADDR_BITS+1:2]];
    if ((a & `REGION_MASK) == `GPIO_BASE) return word_t'(gpio_model); // zero extended
    return '0; // unmapped
  endfunction

  task automatic model_write(input addr_t a, input word_t d, input sel_t s);
    if ((a & `REGION_MASK) == `RAM_BASE) begin
      for (int b = 0; b < `WB_SEL_W; b++) begin
        if (s[b]) ram_model[a[`RAM_ADDR_BITS+1:2]][8*b +: 8] = d[8*b +: 8]; // byte merge
      end
    end else if ((a & `REGION_MASK) == `GPIO_BASE) begin
      gpio_model = d[`GPIO_W-1:0];
    end
  endtask

  task automatic m0_access(input logic we, input addr_t a, input word_t d, input sel_t s,
                           output word_t rd);
    @(posedge sys_clk);
    m0_cyc <= 1'b1;
    m0_stb <= 1'b1;
    m0_we <= we;
    m0_adr <= a;
    m0_dat_w <= d;
    m0_sel <= s;
    do @(negedge sys_clk); while (!m0_ack); // no fixed latency
    rd = m0_dat_r;
    @(posedge sys_clk);
    m0_cyc <= 1'b0;
    m0_stb <= 1'b0;
  endtask

  task automatic m1_access(input logic we, input addr_t a, input word_t d, input sel_t s,
                           output word_t rd);
    @(posedge sys_clk);
    m1_cyc <= 1'b1;
    m1_stb <= 1'b1;
    m1_we <= we;
    m1_adr <= a;
    m1_dat_w <= d;
    m1_sel <= s;
    do @(negedge sys_clk); while (!m1_ack);
    rd = m1_dat_r;
    ack_cycle = cycle_cnt; // used for the uart stall check
    @(posedge sys_clk);
    m1_cyc <= 1'b0;
    m1_stb <= 1'b0;
  endtask

  task automatic read_expect(input logic via_m1, input addr_t a, input string what);
    word_t rd;
    if (via_m1) m1_access(1'b0, a, '0, 4'hF, rd);
    else m0_access(1'b0, a, '0, 4'hF, rd);
    got_q.push_back(rd);
    exp_q.push_back(ref_read(a));
    what_q.push_back(what);
  endtask

  // compare process, drains the result queues every cycle
  initial begin
    forever begin
      @(negedge sys_clk);
      while (got_q.size() > 0)
        check_word(got_q.pop_front(), exp_q.pop_front(), what_q.pop_front());
      while (rx_q.size() > 0) check_byte(rx_q.pop_front(), uart_exp_q.pop_front(), "uart byte");
    end
  end

  // uart monitor, samples mid bit
  initial begin
    logic [7:0] rx;
    forever begin
      @(negedge uart_txd);
      repeat (`UART_DIV / 2) @(negedge sys_clk);
      check_bit(uart_txd, 1'b0, "uart start bit");
      for (int i = 0; i < 8; i++) begin
        repeat (`UART_DIV) @(negedge sys_clk);
        rx[i] = uart_txd; // lsb first
      end
      repeat (`UART_DIV) @(negedge sys_clk);
      check_bit(uart_txd, 1'b1, "uart stop bit");
      rx_q.push_back(rx);
      rx_cnt++;
    end
  end

  initial begin
    addr_t adr, adr_b;
    word_t dat, dat_b, rd, rd_b;
    sel_t sel;
    int a0, a1, ack1;
    logic [7:0] b;
    void'($urandom(32'h30d1));
    {sys_rst, m0_cyc, m0_stb, m0_we, m1_cyc, m1_stb, m1_we} <= 7'b1000000;
    {m0_adr, m0_dat_w, m0_sel, m1_adr, m1_dat_w, m1_sel} <= '0;
    repeat (4) @(posedge sys_clk);
    sys_rst <= 1'b0;
    wait (soc_top_i.core_rst === 1'b0); // synchronizer release
    for (int i = 0; i < 40; i++) begin // ram words with byte selects
      adr = addr_t'($urandom_range(511, 0)) << 2;
      dat = word_t'($urandom());
      model_write(adr, dat, 4'hF);
      m0_access(1'b1, adr, dat, 4'hF, rd); // known word before the partial write
      dat = word_t'($urandom());
      sel = sel_t'($urandom());
      model_write(adr, dat, sel);
      m0_access(1'b1, adr, dat, sel, rd);
      read_expect(1'b0, adr, "ram word");
      ram_adr_q.push_back(adr);
    end
    for (int i = 0; i < 20; i++) begin // both masters in the same cycle
      adr = addr_t'(512 + i) << 2;
      adr_b = addr_t'(768 + i) << 2;
      dat = word_t'($urandom());
      dat_b = word_t'($urandom());
      model_write(adr, dat, 4'hF);
      model_write(adr_b, dat_b, 4'hF);
      a0 = m0_acks;
      a1 = m1_acks;
      fork
        m0_access(1'b1, adr, dat, 4'hF, rd);
        m1_access(1'b1, adr_b, dat_b, 4'hF, rd_b);
      join
      check_word(word_t'(m0_acks - a0), 32'd1, "m0 ack count");
      check_word(word_t'(m1_acks - a1), 32'd1, "m1 ack count");
      read_expect(1'b0, adr, "arbitrated m0 word");
      read_expect(1'b1, adr_b, "arbitrated m1 word");
    end
    model_write(`GPIO_BASE, 32'h1, 4'hF); // gpio and unmapped space
    m1_access(1'b1, `GPIO_BASE, 32'h1, 4'hF, rd);
    read_expect(1'b1, `GPIO_BASE, "gpio readback");
    check_bit(gpio_led, gpio_model[0], "gpio_led");
    read_expect(1'b1, 32'h2000_0000, "unmapped read");
    b = 8'($urandom()); // uart back to back
    uart_exp_q.push_back(b);
    m1_access(1'b1, `UART_BASE, word_t'(b), 4'h1, rd);
    ack1 = ack_cycle;
    m1_access(1'b0, `UART_BASE + `UART_STATUS_OFS, '0, 4'hF, rd);
    check_bit(rd[0], 1'b1, "uart busy flag");
    b = 8'($urandom());
    uart_exp_q.push_back(b);
    m1_access(1'b1, `UART_BASE, word_t'(b), 4'h1, rd);
    // first frame starts one clock after its ack and lasts ten bits
    if (ack_cycle - ack1 < 10 * `UART_DIV + 1)
      stop_with_failure("The second UART write was acked before the first frame ended");
    wait (rx_cnt == 2);
    model_write(`GPIO_BASE, 32'h3, 4'hF); // soft reset request
    m1_access(1'b1, `GPIO_BASE, 32'h3, 4'hF, rd);
    wait (soc_top_i.core_rst === 1'b1);
    wait (soc_top_i.core_rst === 1'b0);
    gpio_model = '0; // cleared by the core reset
    read_expect(1'b1, `GPIO_BASE, "gpio after soft reset");
    check_bit(gpio_led, 1'b0, "gpio_led after soft reset");
    check_bit(uart_txd, 1'b1, "uart_txd after soft reset");
    foreach (ram_adr_q[i]) read_expect(1'b0, ram_adr_q[i], "ram word after soft reset");
    repeat (2) @(negedge sys_clk); // let the compare process drain
    $display("Verification passed");
    $finish;
  end

endmodule

//--- source/soc_gpio.sv
`timescale 1ns/1ns
`include "soc_defines.svh"

module soc_gpio import soc_pkg::*; (
  input  logic              sys_clk,
  input  logic              sys_rst,
  input  logic              stb,
  input  logic              we,
  input  word_t             dat_w,
  output word_t             dat_r,
  output logic              ack,
  output logic [`GPIO_W-1:0] gpio_out // bit 0 led, bit 1 soft reset request
);

  // output register, the core reset brings it back to 0
  always_ff @(posedge sys_clk or posedge sys_rst) begin
    if (sys_rst) begin
      gpio_out <= '0;
      ack      <= 1'b0;
    end else begin
      ack <= stb && !ack;
      if (stb && we && !ack) gpio_out <= dat_w[`GPIO_W-1:0]; // upper bits dropped
    end
  end

  assign dat_r = word_t'(gpio_out); // read back zero extended

endmodule

//--- source/soc_ram.sv
`timescale 1ns/1ns
`include "soc_defines.svh"

module soc_ram import soc_pkg::*; (
  input  logic  sys_clk,
  input  logic  sys_rst,
  input  logic  stb,
  input  logic  we,
  input  addr_t adr,
  input  word_t dat_w,
  input  sel_t  sel,
  output word_t dat_r,
  output logic  ack
);

  localparam int RAM_WORDS = 1 << `RAM_ADDR_BITS;

  word_t                     mem [RAM_WORDS];
  logic [`RAM_ADDR_BITS-1:0] idx; // word index, byte offset dropped

  assign idx = adr[`RAM_ADDR_BITS+1:2];

  // contents survive the soft reset
  always_ff @(posedge sys_clk) begin
    if (stb && !ack) begin
      if (we) begin
        for (int b = 0; b < `WB_SEL_W; b++) begin
          if (sel[b]) mem[idx][8*b +: 8] <= dat_w[8*b +: 8]; // only selected lanes
        end
      end
      dat_r <= mem[idx]; // valid together with ack
    end
  end

  always_ff @(posedge sys_clk or posedge sys_rst) begin
    if (sys_rst) ack <= 1'b0;
    else ack <= stb && !ack; // single cycle pulse
  end

endmodule

//--- source/soc_reset.sv
`timescale 1ns/1ns

module soc_reset (
  input  logic sys_clk,
  input  logic sys_rst,
  input  logic rst_detect, // gpio bit 1
  output logic core_rst
);

  logic       detect_q; // last value of rst_detect
  logic       req_q; // one cycle pulse on a rising edge
  logic       rst_in;
  logic [1:0] sync_q;

  // only the board reset clears the edge detector
  always_ff @(posedge sys_clk or posedge sys_rst) begin
    if (sys_rst) begin
      detect_q <= 1'b1; // no request right out of reset
      req_q    <= 1'b0;
    end else begin
      detect_q <= rst_detect;
      req_q    <= rst_detect && !detect_q;
    end
  end

  assign rst_in = sys_rst || req_q;

  // assert at once, release after two clean edges
  always_ff @(posedge sys_clk or posedge rst_in) begin
    if (rst_in) sync_q <= 2'b11;
    else sync_q <= {sync_q[0], 1'b0};
  end

  assign core_rst = sync_q[1];

endmodule

//--- source/soc_top.sv
`timescale 1ns/1ns
`include "soc_defines.svh"

module soc_top import soc_pkg::*; (
  input  logic  sys_clk,
  input  logic  sys_rst,
  input  logic  m0_cyc, // memory port
  input  logic  m0_stb,
  input  logic  m0_we,
  input  addr_t m0_adr,
  input  word_t m0_dat_w,
  input  sel_t  m0_sel,
  output word_t m0_dat_r,
  output logic  m0_ack,
  input  logic  m1_cyc, // mmio port
  input  logic  m1_stb,
  input  logic  m1_we,
  input  addr_t m1_adr,
  input  word_t m1_dat_w,
  input  sel_t  m1_sel,
  output word_t m1_dat_r,
  output logic  m1_ack,
  output logic  uart_txd,
  output logic  gpio_led
);

  logic               core_rst; // board reset or soft reset
  logic               bus_cyc;
  logic               bus_stb;
  logic               bus_we;
  addr_t              bus_adr;
  word_t              bus_dat_w;
  sel_t               bus_sel;
  logic               bus_ack;
  word_t              bus_dat_r;
  logic               ram_stb;
  logic               ram_ack;
  word_t              ram_dat_r;
  logic               gpio_stb;
  logic               gpio_ack;
  word_t              gpio_dat_r;
  logic               uart_stb;
  logic               uart_ack;
  word_t              uart_dat_r;
  logic [`GPIO_W-1:0] gpio;

  assign gpio_led = gpio[0];

  soc_reset soc_reset_i (
    .sys_clk(sys_clk), .sys_rst(sys_rst), .rst_detect(gpio[1]), .core_rst(core_rst)
  );

  wb_arbiter wb_arbiter_i (
    .sys_clk(sys_clk), .sys_rst(core_rst),
    .m0_cyc(m0_cyc), .m0_stb(m0_stb), .m0_we(m0_we), .m0_adr(m0_adr),
    .m0_dat_w(m0_dat_w), .m0_sel(m0_sel), .m0_dat_r(m0_dat_r), .m0_ack(m0_ack),
    .m1_cyc(m1_cyc), .m1_stb(m1_stb), .m1_we(m1_we), .m1_adr(m1_adr),
    .m1_dat_w(m1_dat_w), .m1_sel(m1_sel), .m1_dat_r(m1_dat_r), .m1_ack(m1_ack),
    .bus_ack(bus_ack), .bus_dat_r(bus_dat_r), .bus_cyc(bus_cyc), .bus_stb(bus_stb),
    .bus_we(bus_we), .bus_adr(bus_adr), .bus_dat_w(bus_dat_w), .bus_sel(bus_sel)
  );

  wb_decoder wb_decoder_i (
    .sys_clk(sys_clk), .sys_rst(core_rst),
    .bus_cyc(bus_cyc), .bus_stb(bus_stb), .bus_adr(bus_adr),
    .ram_ack(ram_ack), .ram_dat_r(ram_dat_r), .gpio_ack(gpio_ack), .gpio_dat_r(gpio_dat_r),
    .uart_ack(uart_ack), .uart_dat_r(uart_dat_r),
    .ram_stb(ram_stb), .gpio_stb(gpio_stb), .uart_stb(uart_stb),
    .bus_ack(bus_ack), .bus_dat_r(bus_dat_r)
  );

  soc_ram soc_ram_i (
    .sys_clk(sys_clk), .sys_rst(core_rst), .stb(ram_stb), .we(bus_we), .adr(bus_adr),
    .dat_w(bus_dat_w), .sel(bus_sel), .dat_r(ram_dat_r), .ack(ram_ack)
  );

  soc_gpio soc_gpio_i (
    .sys_clk(sys_clk), .sys_rst(core_rst), .stb(gpio_stb), .we(bus_we),
    .dat_w(bus_dat_w), .dat_r(gpio_dat_r), .ack(gpio_ack), .gpio_out(gpio)
  );

  uart_tx uart_tx_i (
    .sys_clk(sys_clk), .sys_rst(core_rst), .stb(uart_stb), .we(bus_we), .adr(bus_adr),
    .dat_w(bus_dat_w), .dat_r(uart_dat_r), .ack(uart_ack), .txd(uart_txd)
  );

endmodule

//--- source/uart_tx.sv
`timescale 1ns/1ns
`include "soc_defines.svh"

module uart_tx import soc_pkg::*; (
  input  logic  sys_clk,
  input  logic  sys_rst,
  input  logic  stb,
  input  logic  we,
  input  addr_t adr,
  input  word_t dat_w,
  output word_t dat_r,
  output logic  ack,
  output logic  txd
);

  localparam int BAUD_W = $clog2(`UART_DIV);

  uart_state_t       state;
  logic [BAUD_W-1:0] baud_cnt; // clocks inside the current bit
  logic [2:0]        bit_cnt; // data bit number
  logic [7:0]        shift_q; // lsb goes out first
  logic [7:0]        data_q; // last byte written
  logic              is_status;
  logic              busy;
  logic              data_wr;
  logic              accept;
  logic              bit_end;
  logic              line_bit;

  assign is_status = (adr[3:0] == 4'(`UART_STATUS_OFS));
  assign busy      = (state != tx_idle);
  assign data_wr   = stb && we && !is_status;
  assign accept    = data_wr && !ack && !busy; // byte taken only when idle
  assign bit_end   = (baud_cnt == BAUD_W'(`UART_DIV - 1));

  // a data write while busy waits here without ack, which stalls the bus
  always_ff @(posedge sys_clk or posedge sys_rst) begin
    if (sys_rst) ack <= 1'b0;
    else ack <= stb && !ack && !(data_wr && busy);
  end

  always_ff @(posedge sys_clk) begin
    if (stb && !ack) dat_r <= is_status ? word_t'(busy) : word_t'(data_q);
    if (accept) data_q <= dat_w[7:0];
  end

  always_ff @(posedge sys_clk) begin
    if (accept) shift_q <= dat_w[7:0];
    else if (state == tx_data && bit_end) shift_q <= shift_q >> 1;
  end

  // line level for the state being left, registered one clock later
  always_comb begin
    case (state)
      tx_start: line_bit = 1'b0;
      tx_data:  line_bit = shift_q[0];
      default:  line_bit = 1'b1; // idle and stop
    endcase
  end

  always_ff @(posedge sys_clk or posedge sys_rst) begin
    if (sys_rst) begin
      state    <= tx_idle;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      txd      <= 1'b1;
    end else begin
      txd      <= line_bit; // frame starts the clock after the ack
      baud_cnt <= (state == tx_idle || bit_end) ? '0 : baud_cnt + 1'b1;
      case (state)
        tx_idle:  if (accept) state <= tx_start;
        tx_start: if (bit_end) state <= tx_data;
        tx_data: begin
          if (bit_end) begin
            bit_cnt <= bit_cnt + 1'b1; // wraps back to 0 after bit 7
            if (bit_cnt == 3'd7) state <= tx_stop;
          end
        end
        tx_stop:  if (bit_end) state <= tx_idle;
        default:  state <= tx_idle;
      endcase
    end
  end

endmodule
